/* test/wb_soc_stim.txt */
# Columns in hex: W addr data sel | R addr expected | E addr (expects err)
# G gpio_i value (read back from GPIO_IN) | O expected gpio_o | T test name
W 00000000 11223344 f
W 00000004 aabbccdd f
R 00000000 11223344
W 00000000 000000ee 1
W 00000004 55660000 c
R 00000000 112233ee
R 00000004 5566ccdd
T sram_byte_lanes
E 00000400
E 00030000
R 00000000 112233ee
T decode_error
W 00010000 00000001 f
W 00010004 00000001 f
W 00010004 00000002 f
W 00010004 80000000 f
W 00010004 00000010 f
W 00010004 ffffffff f
R 00010008 00000041
R 0001000c 00000005
W 00010000 00000001 f
R 00010008 00000000
R 0001000c 00000000
T checksum
W 00020000 000000a5 f
O a5
R 00020000 000000a5
G 3c
G c3
W 00020004 000000ff f
O a5
R 00020000 000000a5
R 00020004 000000c3
T gpio

/* wb_soc.f */
rtl/wb_sys_pkg.sv
rtl/wb_if.sv
rtl/wb_decode_err.sv
rtl/wb_sram.sv
rtl/wb_checksum_regs.sv
rtl/wb_checksum_unit.sv
rtl/wb_gpio.sv
rtl/wb_interconnect_1x3.sv
rtl/wb_soc_top.sv
test/tb_wb_soc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_wb_soc -o sim_wb_soc -f wb_soc.f \
	&& ./obj_dir/sim_wb_soc | tee /dev/stderr | grep -q "^NO ERRORS$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* test/tb_wb_soc.sv */
//**********************************************************************
// Testbench of the Wishbone system top level
// Runs the bus operations listed in the stim file, then a random SRAM
// test, checks every response and prints one line per test
//**********************************************************************
`timescale 1ns/1ns

module tb_wb_soc;

	localparam int CLK_PERIOD = 8;
	localparam int RAND_COUNT = 32;
	// Cycles allowed per stim line or random bus operation
	localparam int CYCLES_PER_OP = 20;

	logic        clk;
	logic        rstn;
	logic [31:0] m_adr;
	logic [31:0] m_dat_w;
	logic [3:0]  m_sel;
	logic        m_we;
	logic        m_cyc;
	logic        m_stb;
	logic [31:0] m_dat_r;
	logic        m_ack;
	logic        m_err;
	logic [7:0]  gpio_in;
	logic [7:0]  gpio_out;

	string       stim_q[$];
	logic [7:0]  rand_idx_q[$];
	logic [31:0] model[256];
	bit          stim_ready;
	int          errors;
	int          test_errors;
	int          tests_passed;
	int          tests_failed;

	wb_soc_top i_wb_soc_top (
		.clk     (clk),
		.rstn    (rstn),
		.m_adr_i (m_adr),
		.m_dat_i (m_dat_w),
		.m_sel_i (m_sel),
		.m_we_i  (m_we),
		.m_cyc_i (m_cyc),
		.m_stb_i (m_stb),
		.m_dat_o (m_dat_r),
		.m_ack_o (m_ack),
		.m_err_o (m_err),
		.gpio_i  (gpio_in),
		.gpio_o  (gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_fail(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail (%0d mismatches)", name, test_errors);
		end
		test_errors = 0;
	endtask

	// One classic cycle, held until ack or err, latency counted in cycles
	task automatic bus_cycle(input logic [31:0] adr, input logic [31:0] dat,
			input logic [3:0] sel, input logic we,
			output logic [31:0] rdat, output logic ack, output logic err);
		int lat;
		@(negedge clk);
		m_adr   = adr;
		m_dat_w = dat;
		m_sel   = sel;
		m_we    = we;
		m_cyc   = 1'b1;
		m_stb   = 1'b1;
		lat     = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (m_ack !== 1'b1 && m_err !== 1'b1);
		rdat  = m_dat_r;
		ack   = m_ack;
		err   = m_err;
		// Request stays up through the rising edge that samples the answer
		@(negedge clk);
		m_cyc = 1'b0;
		m_stb = 1'b0;
		m_we  = 1'b0;
		if (lat != 2) begin
			report_fail($sformatf("answer after %0d cycles at adr %h, expected 2", lat, adr));
		end
	endtask

	// Decode and run one stim line
	task automatic run_stim_line(input string line);
		byte         op;
		string       rest;
		int          n;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] rd;
		logic        ack;
		logic        err;
		op   = line.getc(0);
		rest = line.substr(1, line.len() - 1);
		case (op)
			"W": begin
				n = $sscanf(rest, "%h %h %h", f1, f2, f3);
				if (n != 3) begin
					$display("Stim line has too few fields: %s", line);
					errors++;
					test_errors++;
				end
				bus_cycle(f1, f2, f3[3:0], 1'b1, rd, ack, err);
				if (ack !== 1'b1 || err !== 1'b0) begin
					report_fail($sformatf("write %h: ack %b err %b, expected ack", f1, ack, err));
				end
			end
			"R": begin
				n = $sscanf(rest, "%h %h", f1, f2);
				bus_cycle(f1, 32'h0, 4'hf, 1'b0, rd, ack, err);
				if (ack !== 1'b1 || err !== 1'b0) begin
					report_fail($sformatf("read %h: ack %b err %b, expected ack", f1, ack, err));
				end
				if (rd !== f2) begin
					report_fail($sformatf("read %h: got %h, expected %h", f1, rd, f2));
				end
			end
			"E": begin
				n = $sscanf(rest, "%h", f1);
				bus_cycle(f1, 32'h0, 4'hf, 1'b0, rd, ack, err);
				if (err !== 1'b1 || ack !== 1'b0) begin
					report_fail($sformatf("access %h: ack %b err %b, expected err", f1, ack, err));
				end
				if (rd !== 32'h0) begin
					report_fail($sformatf("access %h: data %h on err, expected 0", f1, rd));
				end
			end
			"G": begin
				n = $sscanf(rest, "%h", f1);
				@(negedge clk);
				gpio_in = f1[7:0];
				// Two synchronizer flops plus margin
				repeat (4) @(negedge clk);
				bus_cycle(wb_sys_pkg::GPIO_BASE | 32'h4, 32'h0, 4'hf, 1'b0, rd, ack, err);
				if (rd !== {24'h0, f1[7:0]}) begin
					report_fail($sformatf("GPIO_IN got %h, expected %h", rd, f1[7:0]));
				end
			end
			"O": begin
				n = $sscanf(rest, "%h", f1);
				@(negedge clk);
				if (gpio_out !== f1[7:0]) begin
					report_fail($sformatf("gpio_o got %h, expected %h", gpio_out, f1[7:0]));
				end
			end
			"T": begin
				finish_test(rest.substr(1, rest.len() - 1));
			end
			default: begin
				$display("Unknown operation in stim line: %s", line);
				errors++;
				test_errors++;
			end
		endcase
	endtask

	// Watchdog sized from the number of bus operations
	initial begin
		longint limit_ns;
		wait (stim_ready);
		limit_ns = longint'(stim_q.size() + 2 * RAND_COUNT) * CYCLES_PER_OP * CLK_PERIOD;
		#(limit_ns);
		$display("Simulation timed out, a bus cycle got no ack or err");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		int          fd;
		string       line;
		logic [31:0] rnd;
		logic [31:0] rd;
		logic        ack;
		logic        err;
		logic [7:0]  idx;
		rstn    = 1'b0;
		m_adr   = '0;
		m_dat_w = '0;
		m_sel   = '0;
		m_we    = 1'b0;
		m_cyc   = 1'b0;
		m_stb   = 1'b0;
		gpio_in = '0;
		fd = $fopen("test/wb_soc_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stim file test/wb_soc_stim.txt");
			$display("ERRORS FOUND");
			$finish;
		end else begin
			// Keep operation lines only, without line ends
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0a ||
							line.getc(line.len() - 1) == 8'h0d)) begin
						line = line.substr(0, line.len() - 2);
					end
					if (line.len() > 0 && line.getc(0) != "#") begin
						stim_q.push_back(line);
					end
				end
			end
			$fclose(fd);
			stim_ready = 1'b1;
			repeat (3) @(negedge clk);
			rstn = 1'b1;
			foreach (stim_q[i]) begin
				run_stim_line(stim_q[i]);
			end
			// Random SRAM words at random word addresses
			rnd = 32'h7394_ad94;
			for (int i = 0; i < RAND_COUNT; i++) begin
				rnd = xorshift32(rnd);
				idx = rnd[7:0];
				rnd = xorshift32(rnd);
				bus_cycle({22'h0, idx, 2'b00}, rnd, 4'hf, 1'b1, rd, ack, err);
				if (ack !== 1'b1 || err !== 1'b0) begin
					report_fail($sformatf("random write word %0d: no ack", idx));
				end
				model[idx] = rnd;
				rand_idx_q.push_back(idx);
			end
			foreach (rand_idx_q[i]) begin
				idx = rand_idx_q[i];
				bus_cycle({22'h0, idx, 2'b00}, 32'h0, 4'hf, 1'b0, rd, ack, err);
				if (rd !== model[idx]) begin
					report_fail($sformatf("random read word %0d: got %h, expected %h",
						idx, rd, model[idx]));
				end
			end
			finish_test("random_sram");
			$display("Tests passed %0d, tests failed %0d, mismatches %0d",
				tests_passed, tests_failed, errors);
			if (errors == 0) begin
				$display("NO ERRORS");
			end else begin
				$display("ERRORS FOUND");
			end
			$finish;
		end
	end

endmodule

/* rtl/wb_soc_top.sv */
//********************************************************************
// Top of the Wishbone system
// External master on plain ports, interconnect to SRAM, checksum
// accelerator and GPIO, address map taken from the shared package
//********************************************************************
`timescale 1ns/1ns

module wb_soc_top (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic [wb_sys_pkg::ADDR_WIDTH-1:0]   m_adr_i,
	input  logic [wb_sys_pkg::DATA_WIDTH-1:0]   m_dat_i,
	input  logic [wb_sys_pkg::DATA_WIDTH/8-1:0] m_sel_i,
	input  logic                                m_we_i,
	input  logic                                m_cyc_i,
	input  logic                                m_stb_i,
	output logic [wb_sys_pkg::DATA_WIDTH-1:0]   m_dat_o,
	output logic                                m_ack_o,
	output logic                                m_err_o,
	input  logic [wb_sys_pkg::GPIO_WIDTH-1:0]   gpio_i,
	output logic [wb_sys_pkg::GPIO_WIDTH-1:0]   gpio_o
);

	localparam int AW = wb_sys_pkg::ADDR_WIDTH;
	localparam int DW = wb_sys_pkg::DATA_WIDTH;
	// 1 KB window of 32-bit words gives 256
	localparam int SRAM_WORDS = int'((wb_sys_pkg::SRAM_LIMIT - wb_sys_pkg::SRAM_BASE + 1) / 4);

	logic          chk_clear;
	logic          chk_feed;
	logic [DW-1:0] chk_feed_data;
	logic [DW-1:0] chk_result;
	logic [DW-1:0] chk_count;

	wb_if #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) m_bus ();
	wb_if #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) s_sram ();
	wb_if #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) s_chk ();
	wb_if #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) s_gpio ();

	// Master port onto the internal bus
	assign m_bus.adr   = m_adr_i;
	assign m_bus.dat_w = m_dat_i;
	assign m_bus.sel   = m_sel_i;
	assign m_bus.we    = m_we_i;
	assign m_bus.cyc   = m_cyc_i;
	assign m_bus.stb   = m_stb_i;
	assign m_dat_o     = m_bus.dat_r;
	assign m_ack_o     = m_bus.ack;
	assign m_err_o     = m_bus.err;

	wb_interconnect_1x3 #(
		.ADDR_WIDTH   (AW),
		.DATA_WIDTH   (DW),
		.SLAVE0_BASE  (wb_sys_pkg::SRAM_BASE),
		.SLAVE0_LIMIT (wb_sys_pkg::SRAM_LIMIT),
		.SLAVE1_BASE  (wb_sys_pkg::CHK_BASE),
		.SLAVE1_LIMIT (wb_sys_pkg::CHK_LIMIT),
		.SLAVE2_BASE  (wb_sys_pkg::GPIO_BASE),
		.SLAVE2_LIMIT (wb_sys_pkg::GPIO_LIMIT)
	) i_wb_interconnect_1x3 (
		.clk  (clk),
		.rstn (rstn),
		.m0   (m_bus),
		.s0   (s_sram),
		.s1   (s_chk),
		.s2   (s_gpio)
	);

	wb_sram #(
		.DATA_WIDTH (DW),
		.SRAM_WORDS (SRAM_WORDS)
	) i_wb_sram (
		.clk  (clk),
		.rstn (rstn),
		.bus  (s_sram)
	);

	wb_checksum_regs #(
		.DATA_WIDTH (DW)
	) i_wb_checksum_regs (
		.clk         (clk),
		.rstn        (rstn),
		.bus         (s_chk),
		.clear_o     (chk_clear),
		.feed_o      (chk_feed),
		.feed_data_o (chk_feed_data),
		.result_i    (chk_result),
		.count_i     (chk_count)
	);

	wb_checksum_unit #(
		.DATA_WIDTH (DW)
	) i_wb_checksum_unit (
		.clk         (clk),
		.rstn        (rstn),
		.clear_i     (chk_clear),
		.feed_i      (chk_feed),
		.feed_data_i (chk_feed_data),
		.result_o    (chk_result),
		.count_o     (chk_count)
	);

	wb_gpio #(
		.DATA_WIDTH (DW),
		.GPIO_WIDTH (wb_sys_pkg::GPIO_WIDTH)
	) i_wb_gpio (
		.clk    (clk),
		.rstn   (rstn),
		.bus    (s_gpio),
		.gpio_i (gpio_i),
		.gpio_o (gpio_o)
	);

endmodule

/* rtl/wb_interconnect_1x3.sv */
//********************************************************************
// One master, three slave Wishbone interconnect
// Decodes the address on the first request cycle, then routes the
// transfer to the chosen slave or to the built-in decode-error target
//********************************************************************
`timescale 1ns/1ns

module wb_interconnect_1x3 #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter logic [ADDR_WIDTH-1:0] SLAVE0_BASE  = '0,
	parameter logic [ADDR_WIDTH-1:0] SLAVE0_LIMIT = '0,
	parameter logic [ADDR_WIDTH-1:0] SLAVE1_BASE  = '0,
	parameter logic [ADDR_WIDTH-1:0] SLAVE1_LIMIT = '0,
	parameter logic [ADDR_WIDTH-1:0] SLAVE2_BASE  = '0,
	parameter logic [ADDR_WIDTH-1:0] SLAVE2_LIMIT = '0
) (
	input logic  clk,
	input logic  rstn,
	wb_if.slave  m0,
	wb_if.master s0,
	wb_if.master s1,
	wb_if.master s2
);

	// Target index 3 is the decode-error target
	localparam logic [1:0] TGT_ERR = 2'd3;

	wb_sys_pkg::ic_state_e state_q;
	logic [1:0]            tgt_q;
	logic [3:0]            tgt_en;
	logic [DATA_WIDTH-1:0] rsp_dat;
	logic                  rsp_ack;
	logic                  rsp_err;

	// Bus to the decode-error target
	wb_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) serr ();

	// First matching window wins
	function automatic logic [1:0] addr2tgt(input logic [ADDR_WIDTH-1:0] addr);
		if (addr >= SLAVE0_BASE && addr <= SLAVE0_LIMIT) begin
			return 2'd0;
		end
		if (addr >= SLAVE1_BASE && addr <= SLAVE1_LIMIT) begin
			return 2'd1;
		end
		if (addr >= SLAVE2_BASE && addr <= SLAVE2_LIMIT) begin
			return 2'd2;
		end
		return TGT_ERR;
	endfunction

	// Request FSM, target latched on the edge that sees cyc and stb
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= wb_sys_pkg::IC_IDLE;
			tgt_q   <= TGT_ERR;
		end else begin
			case (state_q)
				wb_sys_pkg::IC_IDLE: begin
					if (m0.cyc && m0.stb) begin
						tgt_q   <= addr2tgt(m0.adr);
						state_q <= wb_sys_pkg::IC_BUSY;
					end
				end
				wb_sys_pkg::IC_BUSY: begin
					// Done on the edge that sees the answer with stb still high
					if (m0.stb && (rsp_ack || rsp_err)) begin
						state_q <= wb_sys_pkg::IC_IDLE;
					end
				end
				default: state_q <= wb_sys_pkg::IC_IDLE;
			endcase
		end
	end

	// One-hot enable of the chosen target while busy
	assign tgt_en = (state_q == wb_sys_pkg::IC_BUSY) ? (4'b0001 << tgt_q) : 4'b0000;

	// Request fan-out, unselected targets see zeros
	assign s0.adr     = tgt_en[0] ? m0.adr : '0;
	assign s0.dat_w   = tgt_en[0] ? m0.dat_w : '0;
	assign s0.sel     = tgt_en[0] ? m0.sel : '0;
	assign s0.we      = tgt_en[0] & m0.we;
	assign s0.cyc     = tgt_en[0] & m0.cyc;
	assign s0.stb     = tgt_en[0] & m0.stb;
	assign s1.adr     = tgt_en[1] ? m0.adr : '0;
	assign s1.dat_w   = tgt_en[1] ? m0.dat_w : '0;
	assign s1.sel     = tgt_en[1] ? m0.sel : '0;
	assign s1.we      = tgt_en[1] & m0.we;
	assign s1.cyc     = tgt_en[1] & m0.cyc;
	assign s1.stb     = tgt_en[1] & m0.stb;
	assign s2.adr     = tgt_en[2] ? m0.adr : '0;
	assign s2.dat_w   = tgt_en[2] ? m0.dat_w : '0;
	assign s2.sel     = tgt_en[2] ? m0.sel : '0;
	assign s2.we      = tgt_en[2] & m0.we;
	assign s2.cyc     = tgt_en[2] & m0.cyc;
	assign s2.stb     = tgt_en[2] & m0.stb;
	assign serr.adr   = tgt_en[3] ? m0.adr : '0;
	assign serr.dat_w = tgt_en[3] ? m0.dat_w : '0;
	assign serr.sel   = tgt_en[3] ? m0.sel : '0;
	assign serr.we    = tgt_en[3] & m0.we;
	assign serr.cyc   = tgt_en[3] & m0.cyc;
	assign serr.stb   = tgt_en[3] & m0.stb;

	// Response mux, all zero when idle
	always_comb begin
		rsp_dat = '0;
		rsp_ack = 1'b0;
		rsp_err = 1'b0;
		if (state_q == wb_sys_pkg::IC_BUSY) begin
			case (tgt_q)
				2'd0: begin
					rsp_dat = s0.dat_r;
					rsp_ack = s0.ack;
					rsp_err = s0.err;
				end
				2'd1: begin
					rsp_dat = s1.dat_r;
					rsp_ack = s1.ack;
					rsp_err = s1.err;
				end
				2'd2: begin
					rsp_dat = s2.dat_r;
					rsp_ack = s2.ack;
					rsp_err = s2.err;
				end
				default: begin
					rsp_dat = serr.dat_r;
					rsp_ack = serr.ack;
					rsp_err = serr.err;
				end
			endcase
		end
	end

	assign m0.dat_r = rsp_dat;
	assign m0.ack   = rsp_ack;
	assign m0.err   = rsp_err;

	wb_decode_err i_wb_decode_err (
		.clk  (clk),
		.rstn (rstn),
		.bus  (serr)
	);

	// Whatever the target does, the master never sees both answers
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
		!(m0.ack && m0.err));

	// Only one target is ever addressed
	a_one_stb: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0({s0.stb, s1.stb, s2.stb, serr.stb}));

endmodule

/* rtl/wb_gpio.sv */
//********************************************************************
// GPIO block, one output register and one synchronized input register
// GPIO_OUT drives the pins, GPIO_IN shows gpio_i after two flops
//********************************************************************
`timescale 1ns/1ns

module wb_gpio #(
	parameter int DATA_WIDTH = 32,
	parameter int GPIO_WIDTH = 8
) (
	input  logic                  clk,
	input  logic                  rstn,
	wb_if.slave                   bus,
	input  logic [GPIO_WIDTH-1:0] gpio_i,
	output logic [GPIO_WIDTH-1:0] gpio_o
);

	wb_sys_pkg::gpio_reg_e reg_sel;
	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] sync1_q;
	logic [GPIO_WIDTH-1:0] sync2_q;
	logic [DATA_WIDTH-1:0] rd_q;
	logic                  ack_q;
	logic                  req;

	assign req     = bus.cyc & bus.stb & ~ack_q;
	assign reg_sel = wb_sys_pkg::gpio_reg_e'(bus.adr[3:2]);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q   <= 1'b0;
			out_q   <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			ack_q   <= req;
			// Two-flop synchronizer for the asynchronous pins
			sync1_q <= gpio_i;
			sync2_q <= sync1_q;
			// Only GPIO_OUT is writable
			if (req && bus.we && reg_sel == wb_sys_pkg::GPIO_OUT) begin
				out_q <= bus.dat_w[GPIO_WIDTH-1:0];
			end
		end
	end

	// Upper bits and unmapped offsets read zero
	always_ff @(posedge clk) begin
		if (req) begin
			rd_q <= '0;
			case (reg_sel)
				wb_sys_pkg::GPIO_OUT: rd_q[GPIO_WIDTH-1:0] <= out_q;
				wb_sys_pkg::GPIO_IN:  rd_q[GPIO_WIDTH-1:0] <= sync2_q;
				default: ;
			endcase
		end
	end

	assign gpio_o    = out_q;
	assign bus.dat_r = rd_q;
	assign bus.ack   = ack_q;
	assign bus.err   = 1'b0;

endmodule

/* rtl/wb_checksum_unit.sv */
//********************************************************************
// Rotate-and-add checksum engine
// Each feed rotates the sum left by one, adds the word and counts it
//********************************************************************
`timescale 1ns/1ns

module wb_checksum_unit #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  clear_i,
	input  logic                  feed_i,
	input  logic [DATA_WIDTH-1:0] feed_data_i,
	output logic [DATA_WIDTH-1:0] result_o,
	output logic [DATA_WIDTH-1:0] count_o
);

	logic [DATA_WIDTH-1:0] result_q;
	logic [DATA_WIDTH-1:0] count_q;

	always_ff @(posedge clk) begin
		if (!rstn || clear_i) begin
			result_q <= '0;
			count_q  <= '0;
		end else if (feed_i) begin
			// Sum wraps modulo 2^DATA_WIDTH
			result_q <= {result_q[DATA_WIDTH-2:0], result_q[DATA_WIDTH-1]} + feed_data_i;
			count_q  <= count_q + 1'b1;
		end
	end

	assign result_o = result_q;
	assign count_o  = count_q;

endmodule

/* rtl/wb_checksum_regs.sv */
//********************************************************************
// Register block of the checksum accelerator
// CTRL bit 0 clears the engine, DATA feeds one word, RESULT and COUNT
// read back the engine state
//********************************************************************
`timescale 1ns/1ns

module wb_checksum_regs #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rstn,
	wb_if.slave                   bus,
	output logic                  clear_o,
	output logic                  feed_o,
	output logic [DATA_WIDTH-1:0] feed_data_o,
	input  logic [DATA_WIDTH-1:0] result_i,
	input  logic [DATA_WIDTH-1:0] count_i
);

	wb_sys_pkg::chk_reg_e  reg_sel;
	logic [DATA_WIDTH-1:0] rd_q;
	logic                  ack_q;
	logic                  req;
	logic                  wr;

	assign req     = bus.cyc & bus.stb & ~ack_q;
	assign wr      = req & bus.we;
	// sel is not decoded, every write is a full word
	assign reg_sel = wb_sys_pkg::chk_reg_e'(bus.adr[3:2]);

	// Engine strobes, they land on the same edge as ack
	assign clear_o     = wr && (reg_sel == wb_sys_pkg::CHK_CTRL) && bus.dat_w[0];
	assign feed_o      = wr && (reg_sel == wb_sys_pkg::CHK_DATA);
	assign feed_data_o = bus.dat_w;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	// Read mux, CTRL and DATA are write-only and read as zero
	always_ff @(posedge clk) begin
		if (req) begin
			case (reg_sel)
				wb_sys_pkg::CHK_RESULT: rd_q <= result_i;
				wb_sys_pkg::CHK_COUNT:  rd_q <= count_i;
				default:                rd_q <= '0;
			endcase
		end
	end

	assign bus.dat_r = rd_q;
	assign bus.ack   = ack_q;
	assign bus.err   = 1'b0;

	// Engine never sees clear and feed in one cycle
	a_clear_feed: assert property (@(posedge clk) disable iff (!rstn)
		!(clear_o && feed_o));

endmodule

/* rtl/wb_sram.sv */
//********************************************************************
// Single-port word RAM on a Wishbone slave port
// Word index from address bits above the byte offset, writes honor sel
//********************************************************************
`timescale 1ns/1ns

module wb_sram #(
	parameter int DATA_WIDTH = 32,
	parameter int SRAM_WORDS = 256
) (
	input logic clk,
	input logic rstn,
	wb_if.slave bus
);

	localparam int IDX_W = $clog2(SRAM_WORDS);
	localparam int LANES = DATA_WIDTH / 8;

	logic [DATA_WIDTH-1:0] mem [SRAM_WORDS];
	logic [DATA_WIDTH-1:0] rd_q;
	logic [IDX_W-1:0]      word_idx;
	logic                  ack_q;
	logic                  req;

	// New request, ignoring the stb still high in the cycle after ack
	assign req      = bus.cyc & bus.stb & ~ack_q;
	// Bits [9:2] for 256 words
	assign word_idx = bus.adr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	// Storage and read register
	always_ff @(posedge clk) begin
		if (req && bus.we) begin
			for (int i = 0; i < LANES; i++) begin
				if (bus.sel[i]) begin
					mem[word_idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
				end
			end
		end
		// Old word is captured, fine for reads since writes return no data
		if (req) begin
			rd_q <= mem[word_idx];
		end
	end

	assign bus.dat_r = rd_q;
	assign bus.ack   = ack_q;
	assign bus.err   = 1'b0;

endmodule

/* rtl/wb_decode_err.sv */
//********************************************************************
// Decode-error target of the interconnect
// Any request that lands here gets a single-cycle err, never ack
//********************************************************************
`timescale 1ns/1ns

module wb_decode_err (
	input logic clk,
	input logic rstn,
	wb_if.slave bus
);

	logic err_q;

	// Answer one edge after the request, skip the cycle after err
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= bus.cyc & bus.stb & ~err_q;
		end
	end

	assign bus.err   = err_q;
	assign bus.ack   = 1'b0;
	// No data behind this target
	assign bus.dat_r = '0;

	// The master drops stb after err, so a second err means a stuck handshake
	a_err_single: assert property (@(posedge clk) disable iff (!rstn)
		bus.err |=> !bus.err);

endmodule

/* rtl/wb_if.sv */
//********************************************************************
// Wishbone classic bus, single transfers only
// The master modport drives the request, the slave modport answers
//********************************************************************
`timescale 1ns/1ns

interface wb_if #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32
) ();

	// Request side, held by the master until ack or err
	logic [ADDR_WIDTH-1:0]   adr;
	logic [DATA_WIDTH-1:0]   dat_w;
	logic [DATA_WIDTH/8-1:0] sel;
	logic                    we;
	logic                    cyc;
	logic                    stb;

	// Response side
	// dat_r only meaningful in the ack cycle of a read
	logic [DATA_WIDTH-1:0]   dat_r;
	logic                    ack;
	logic                    err;

	modport master (
		output adr,
		output dat_w,
		output sel,
		output we,
		output cyc,
		output stb,
		input  dat_r,
		input  ack,
		input  err
	);

	modport slave (
		input  adr,
		input  dat_w,
		input  sel,
		input  we,
		input  cyc,
		input  stb,
		output dat_r,
		output ack,
		output err
	);

endinterface

/* rtl/wb_sys_pkg.sv */
//********************************************************************
// Shared constants and types for the Wishbone system
// Address map, bus widths and the enums used by the interconnect FSM
// and the slave register decoders
//********************************************************************
package wb_sys_pkg;

	// Bus widths, SEL is DATA_WIDTH/8 lanes
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// SRAM window, 256 words
	localparam logic [ADDR_WIDTH-1:0] SRAM_BASE  = 32'h0000_0000;
	localparam logic [ADDR_WIDTH-1:0] SRAM_LIMIT = 32'h0000_03FF;

	// Checksum accelerator window
	localparam logic [ADDR_WIDTH-1:0] CHK_BASE  = 32'h0001_0000;
	localparam logic [ADDR_WIDTH-1:0] CHK_LIMIT = 32'h0001_000F;

	// GPIO window
	localparam logic [ADDR_WIDTH-1:0] GPIO_BASE  = 32'h0002_0000;
	localparam logic [ADDR_WIDTH-1:0] GPIO_LIMIT = 32'h0002_000F;
	localparam int GPIO_WIDTH = 8;

	// Interconnect request FSM
	typedef enum logic {
		IC_IDLE,
		IC_BUSY
	} ic_state_e;

	// Checksum register offsets, word offset bits [3:2]
	typedef enum logic [1:0] {
		CHK_CTRL   = 2'd0,
		CHK_DATA   = 2'd1,
		CHK_RESULT = 2'd2,
		CHK_COUNT  = 2'd3
	} chk_reg_e;

	// GPIO register offsets, offsets 2 and 3 are unmapped
	typedef enum logic [1:0] {
		GPIO_OUT = 2'd0,
		GPIO_IN  = 2'd1
	} gpio_reg_e;

endpackage
